//--- hdl/mem_pkg.sv
package mem_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Shared word store geometry
	////////////////////////////////////////////////////////////////////////////

	// One store word holds two cartridge bytes
	localparam int WORD_W = 16;

	typedef logic [WORD_W-1:0] word_t;

	// 8K words, enough for a 16 KB image
	localparam int MEM_ADDR_W_DEFAULT = 13;

endpackage

//--- hdl/cart_pkg.sv
package cart_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Download stream format
	////////////////////////////////////////////////////////////////////////////

	localparam int CART_ADDR_W = 24;

	typedef logic [CART_ADDR_W-1:0] cart_addr_t;
	typedef logic [7:0] dl_index_t;

	// Index used by the host for cheat files
	localparam dl_index_t CODE_INDEX = 8'hFF;

	// Copier header in front of some images
	localparam cart_addr_t HEADER_BYTES = 24'd512;

	// Populous signature blocks and the four words expected at offsets 6..12
	localparam cart_addr_t SIG_BLOCK_A = 24'h001F20;
	localparam cart_addr_t SIG_BLOCK_B = 24'h002120;
	localparam logic [3:0][15:0] SIG_WORDS = {16'h5355, 16'h4F4C, 16'h5550, 16'h4F50};

	// Cheat code layout, top down
	typedef logic [127:0] cheat_code_t;
	localparam int CODE_FLAGS_LSB   = 96;
	localparam int CODE_ADDR_LSB    = 64;
	localparam int CODE_COMPARE_LSB = 32;
	localparam int CODE_REPLACE_LSB = 0;

endpackage

//--- hdl/rom_store.sv
`timescale 1ns/1ns

module rom_store import mem_pkg::*; #(
	parameter int MEM_ADDR_W = MEM_ADDR_W_DEFAULT
) (
	input  logic                  clk_sys,
	input  logic                  mem_en,
	input  logic                  mem_we,
	input  logic [MEM_ADDR_W-1:0] mem_addr,
	input  word_t                 mem_wdata,
	output word_t                 mem_rdata
);

	word_t mem [2**MEM_ADDR_W];

	// Single port, write or registered read per enabled cycle
	always_ff @(posedge clk_sys) begin
		if (mem_en) begin
			if (mem_we) begin
				mem[mem_addr] <= mem_wdata;
			end else begin
				mem_rdata <= mem[mem_addr];
			end
		end
	end

endmodule

//--- hdl/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter import mem_pkg::*; #(
	parameter int MEM_ADDR_W = MEM_ADDR_W_DEFAULT
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	// Writer side
	input  logic                  wr_valid,
	output logic                  wr_ready,
	input  logic [MEM_ADDR_W-1:0] wr_addr,
	input  word_t                 wr_data,
	// Reader side
	input  logic                  rq_valid,
	output logic                  rq_ready,
	input  logic [MEM_ADDR_W-1:0] rq_addr,
	output word_t                 rq_data,
	output logic                  rq_resp,
	// Store side
	output logic                  mem_en,
	output logic                  mem_we,
	output logic [MEM_ADDR_W-1:0] mem_addr,
	output word_t                 mem_wdata,
	input  word_t                 mem_rdata
);

	logic grant_rd;
	logic rd_issued;

	// Writer always wins, a read only gets a cycle with no write pending
	assign wr_ready = 1'b1;
	assign rq_ready = ~wr_valid;
	assign grant_rd = rq_valid && !wr_valid;

	assign mem_en    = wr_valid || grant_rd;
	assign mem_we    = wr_valid;
	assign mem_addr  = wr_valid ? wr_addr : rq_addr;
	assign mem_wdata = wr_data;

	// Store output is registered, so the response trails the grant by one
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_issued <= 1'b0;
		end else begin
			rd_issued <= grant_rd;
		end
	end

	assign rq_resp = rd_issued;
	assign rq_data = mem_rdata;

endmodule

//--- hdl/cart_loader.sv
`timescale 1ns/1ns

module cart_loader import mem_pkg::*, cart_pkg::*; #(
	parameter int MEM_ADDR_W = MEM_ADDR_W_DEFAULT
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active,
	input  dl_index_t             dl_index,
	input  logic                  dl_valid,
	output logic                  dl_ready,
	input  word_t                 dl_data,
	input  logic                  swap,
	output logic                  wr_valid,
	input  logic                  wr_ready,
	output logic [MEM_ADDR_W-1:0] wr_addr,
	output word_t                 wr_data,
	output cart_addr_t            img_bytes,
	output logic                  sgx,
	output logic                  populous
);

	logic       cart_dl;
	logic       cart_q;
	logic       start;
	logic       take;
	cart_addr_t addr_cur;
	word_t      swapped;
	word_t      word_in;
	logic       in_block;
	logic       sig_check;
	logic [1:0] sig_off;
	logic [1:0] pop;

	// Index 0 is a plain cart, index 1 a SuperGrafx cart
	assign cart_dl = dl_active && (dl_index[5:0] <= 6'd1);
	assign start   = cart_dl && !cart_q;

	// Hold the stream off while a write waits for the store
	assign dl_ready = ~wr_valid;
	assign take     = cart_dl && dl_valid && dl_ready;
	assign addr_cur = start ? '0 : img_bytes;

	// ROM data swap reverses the bit order inside each byte
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			swapped[i]     = dl_data[7 - i];
			swapped[8 + i] = dl_data[15 - i];
		end
	end

	assign word_in = swap ? swapped : dl_data;

	////////////////////////////////////////////////////////////////////////////
	// Populous signature words at offsets 6, 8, 10 and 12 of either block
	////////////////////////////////////////////////////////////////////////////

	assign in_block  = (addr_cur[CART_ADDR_W-1:4] == SIG_BLOCK_A[CART_ADDR_W-1:4]) ||
		(addr_cur[CART_ADDR_W-1:4] == SIG_BLOCK_B[CART_ADDR_W-1:4]);
	assign sig_off   = 2'(addr_cur[3:1] - 3'd3);
	assign sig_check = in_block && (addr_cur[3:1] >= 3'd3) &&
		(addr_cur[3:1] <= 3'd6);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_q    <= 1'b0;
			wr_valid  <= 1'b0;
			img_bytes <= '0;
			pop       <= 2'b00;
			sgx       <= 1'b0;
		end else begin
			cart_q <= cart_dl;
			if (wr_valid && wr_ready) begin
				wr_valid  <= 1'b0;
				img_bytes <= img_bytes + 24'd2;
			end
			// New cart download restarts the image
			if (start) begin
				img_bytes <= '0;
				pop       <= 2'b11;
				sgx       <= dl_index[0];
			end
			if (take) begin
				wr_valid <= 1'b1;
				if (sig_check && (word_in != SIG_WORDS[sig_off])) begin
					pop[addr_cur[13]] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			wr_addr <= addr_cur[MEM_ADDR_W:1];
			wr_data <= word_in;
		end
	end

	// Headered image shifts the signature into the other block
	assign populous = pop[img_bytes[9]];

endmodule

//--- hdl/cheat_loader.sv
`timescale 1ns/1ns

module cheat_loader import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_active,
	input  dl_index_t   dl_index,
	input  logic        dl_valid,
	input  logic        dl_ready,
	input  cart_addr_t  dl_addr,
	input  logic [15:0] dl_data,
	output logic        code_valid,
	output cheat_code_t code
);

	logic code_dl;
	logic take;

	assign code_dl = dl_active && (dl_index == CODE_INDEX);
	assign take    = code_dl && dl_valid && dl_ready;

	// Last word of a code makes it available
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= take && (dl_addr[3:0] == 4'd14);
		end
	end

	// Low half of each field first
	always_ff @(posedge clk_sys) begin
		if (take) begin
			case (dl_addr[3:0])
				4'd0:  code[CODE_FLAGS_LSB +: 16]        <= dl_data;
				4'd2:  code[CODE_FLAGS_LSB + 16 +: 16]   <= dl_data;
				4'd4:  code[CODE_ADDR_LSB +: 16]         <= dl_data;
				4'd6:  code[CODE_ADDR_LSB + 16 +: 16]    <= dl_data;
				4'd8:  code[CODE_COMPARE_LSB +: 16]      <= dl_data;
				4'd10: code[CODE_COMPARE_LSB + 16 +: 16] <= dl_data;
				4'd12: code[CODE_REPLACE_LSB +: 16]      <= dl_data;
				4'd14: code[CODE_REPLACE_LSB + 16 +: 16] <= dl_data;
				default: ;
			endcase
		end
	end

endmodule

//--- hdl/rom_reader.sv
`timescale 1ns/1ns

module rom_reader import mem_pkg::*, cart_pkg::*; #(
	parameter int MEM_ADDR_W = MEM_ADDR_W_DEFAULT
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	// Console side
	input  logic                  rd_valid,
	output logic                  rd_ready,
	input  cart_addr_t            rd_addr,
	output logic [7:0]            rd_data,
	output logic                  rd_resp,
	input  cart_addr_t            img_bytes,
	// Arbiter side
	output logic                  rq_valid,
	input  logic                  rq_ready,
	output logic [MEM_ADDR_W-1:0] rq_addr,
	input  word_t                 rq_data,
	input  logic                  rq_resp
);

	logic       busy;
	logic       byte_sel;
	cart_addr_t eff_addr;

	// Skip the copier header when the image size says one is there
	assign eff_addr = rd_addr + (img_bytes[9] ? HEADER_BYTES : '0);

	// One read in flight
	assign rd_ready = ~busy;
	assign rd_resp  = rq_resp;
	assign rd_data  = byte_sel ? rq_data[15:8] : rq_data[7:0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			busy     <= 1'b0;
			rq_valid <= 1'b0;
		end else begin
			if (rd_valid && rd_ready) begin
				busy     <= 1'b1;
				rq_valid <= 1'b1;
			end
			if (rq_valid && rq_ready) begin
				rq_valid <= 1'b0;
			end
			if (rd_resp) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd_valid && rd_ready) begin
			rq_addr  <= eff_addr[MEM_ADDR_W:1];
			byte_sel <= eff_addr[0];
		end
	end

endmodule

//--- hdl/cart_top.sv
`timescale 1ns/1ns

module cart_top import mem_pkg::*, cart_pkg::*; #(
	parameter int MEM_ADDR_W = MEM_ADDR_W_DEFAULT
) (
	input  logic        clk_sys,
	input  logic        reset,
	// Download stream
	input  logic        dl_active,
	input  dl_index_t   dl_index,
	input  logic        dl_valid,
	output logic        dl_ready,
	input  cart_addr_t  dl_addr,
	input  word_t       dl_data,
	input  logic        swap,
	// Console reads
	input  logic        rd_valid,
	output logic        rd_ready,
	input  cart_addr_t  rd_addr,
	output logic [7:0]  rd_data,
	output logic        rd_resp,
	// Status
	output logic        sgx,
	output logic        populous,
	output logic        code_valid,
	output cheat_code_t code
);

	logic                  wr_valid;
	logic                  wr_ready;
	logic [MEM_ADDR_W-1:0] wr_addr;
	word_t                 wr_data;
	logic                  rq_valid;
	logic                  rq_ready;
	logic [MEM_ADDR_W-1:0] rq_addr;
	word_t                 rq_data;
	logic                  rq_resp;
	logic                  mem_en;
	logic                  mem_we;
	logic [MEM_ADDR_W-1:0] mem_addr;
	word_t                 mem_wdata;
	word_t                 mem_rdata;
	cart_addr_t            img_bytes;

	////////////////////////////////////////////////////////////////////////////
	// Stream consumers
	////////////////////////////////////////////////////////////////////////////

	cart_loader #(.MEM_ADDR_W(MEM_ADDR_W)) cart_loader_inst (
		.clk_sys, .reset, .dl_active, .dl_index, .dl_valid, .dl_ready, .dl_data, .swap,
		.wr_valid, .wr_ready, .wr_addr, .wr_data, .img_bytes, .sgx, .populous
	);

	cheat_loader cheat_loader_inst (
		.clk_sys, .reset, .dl_active, .dl_index, .dl_valid, .dl_ready, .dl_addr, .dl_data,
		.code_valid, .code
	);

	// Console read path
	rom_reader #(.MEM_ADDR_W(MEM_ADDR_W)) rom_reader_inst (
		.clk_sys, .reset, .rd_valid, .rd_ready, .rd_addr, .rd_data, .rd_resp, .img_bytes,
		.rq_valid, .rq_ready, .rq_addr, .rq_data, .rq_resp
	);

	////////////////////////////////////////////////////////////////////////////
	// Shared store
	////////////////////////////////////////////////////////////////////////////

	mem_arbiter #(.MEM_ADDR_W(MEM_ADDR_W)) mem_arbiter_inst (
		.clk_sys, .reset, .wr_valid, .wr_ready, .wr_addr, .wr_data,
		.rq_valid, .rq_ready, .rq_addr, .rq_data, .rq_resp,
		.mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
	);

	rom_store #(.MEM_ADDR_W(MEM_ADDR_W)) rom_store_inst (
		.clk_sys, .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
	);

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int HALF_PERIOD  = 2,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #HALF_PERIOD clk_sys = ~clk_sys;
	end

	// Reset released on a falling edge, away from the active edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

//--- dv/cart_chk.sv
`timescale 1ns/1ns

module cart_chk (
	input logic clk_sys,
	input logic reset,
	input logic dl_valid,
	input logic dl_ready,
	input logic rd_valid,
	input logic rd_ready,
	input logic rd_resp,
	input logic wr_valid,
	input logic rq_ready,
	input logic code_valid
);

	int unsigned dl_hold_fails = 0;
	int unsigned rd_ready_fails = 0;
	int unsigned rq_grant_fails = 0;
	int unsigned code_pulse_fails = 0;
	logic        rd_pending;

	// Console read accepted, response not yet returned
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_pending <= 1'b0;
		end else if (rd_valid && rd_ready) begin
			rd_pending <= 1'b1;
		end else if (rd_resp) begin
			rd_pending <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Handshake rules
	////////////////////////////////////////////////////////////////////////////

	dl_hold: assert property (@(posedge clk_sys) disable iff (reset)
		dl_valid && !dl_ready |=> dl_valid)
	else begin
		$error("Download word withdrawn before it was accepted");
		dl_hold_fails++;
	end

	rd_one_outstanding: assert property (@(posedge clk_sys) disable iff (reset)
		rd_pending |-> !rd_ready)
	else begin
		$error("Console read accepted while another read was still outstanding");
		rd_ready_fails++;
	end

	// Writer priority on the shared store
	rq_blocked: assert property (@(posedge clk_sys) disable iff (reset)
		wr_valid |-> !rq_ready)
	else begin
		$error("Read request offered a grant while a write was pending");
		rq_grant_fails++;
	end

	code_single: assert property (@(posedge clk_sys) disable iff (reset)
		code_valid |=> !code_valid)
	else begin
		$error("Cheat code valid held for more than one cycle");
		code_pulse_fails++;
	end

endmodule

//--- dv/cart_tb.sv
`timescale 1ns/1ns

module cart_tb import mem_pkg::*, cart_pkg::*; ();

	localparam int TOTAL_WORDS     = 64 + 64 + 320 + 2 * 'h1100 + 8 + 240 + 64;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 2000;

	logic        clk_sys;
	logic        reset;
	logic        dl_active;
	dl_index_t   dl_index;
	logic        dl_valid;
	logic        dl_ready;
	cart_addr_t  dl_addr;
	word_t       dl_data;
	logic        swap;
	logic        rd_valid;
	logic        rd_ready;
	cart_addr_t  rd_addr;
	logic [7:0]  rd_data;
	logic        rd_resp;
	logic        sgx;
	logic        populous;
	logic        code_valid;
	cheat_code_t code;

	// Download stream bytes and the bytes the store should hold
	logic [7:0]  src [16384];
	logic [7:0]  image [16384];
	logic [31:0] lfsr = 32'd87923;
	int          errors = 0;
	int          code_pulses = 0;

	tb_clock clock_inst (.clk_sys, .reset);

	cart_top cart_top_inst (
		.clk_sys, .reset, .dl_active, .dl_index, .dl_valid, .dl_ready, .dl_addr, .dl_data,
		.swap, .rd_valid, .rd_ready, .rd_addr, .rd_data, .rd_resp, .sgx, .populous,
		.code_valid, .code
	);

	bind cart_top cart_chk cart_chk_inst (
		.clk_sys(clk_sys), .reset(reset), .dl_valid(dl_valid), .dl_ready(dl_ready),
		.rd_valid(rd_valid), .rd_ready(rd_ready), .rd_resp(rd_resp), .wr_valid(wr_valid),
		.rq_ready(rq_ready), .code_valid(code_valid)
	);

	////////////////////////////////////////////////////////////////////////////
	// Random source and reference helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic lfsr_step();
		logic out_bit;
		out_bit = lfsr[0];
		lfsr = lfsr >> 1;
		if (out_bit) begin
			lfsr = lfsr ^ 32'hA300_0000;
		end
		return out_bit;
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_step()};
		end
		return v;
	endfunction

	function automatic logic [7:0] bit_reverse(input logic [7:0] b);
		logic [7:0] r;
		for (int i = 0; i < 8; i++) begin
			r[i] = b[7 - i];
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERROR %0t ns %s expected %0h got %0h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic fill_random(input int first, input int count);
		for (int i = first; i < first + count; i++) begin
			src[i] = 8'(rand_bits(8));
		end
	endtask

	// Little endian, low byte at the even address
	task automatic place_word(input int addr, input word_t w);
		src[addr]     = w[7:0];
		src[addr + 1] = w[15:8];
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus drivers, all entered and left on a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic send_word(input int addr, input word_t data);
		dl_valid = 1'b1;
		dl_addr  = addr[CART_ADDR_W-1:0];
		dl_data  = data;
		while (!dl_ready) @(negedge clk_sys);
		@(negedge clk_sys);
		dl_valid = 1'b0;
	endtask

	task automatic load_image(input dl_index_t index, input logic swap_on, input int words);
		word_t w;
		dl_active = 1'b0;
		@(negedge clk_sys);
		dl_index  = index;
		swap      = swap_on;
		dl_active = 1'b1;
		for (int i = 0; i < words; i++) begin
			w = {src[2*i + 1], src[2*i]};
			image[2*i]     = swap_on ? bit_reverse(src[2*i]) : src[2*i];
			image[2*i + 1] = swap_on ? bit_reverse(src[2*i + 1]) : src[2*i + 1];
			send_word(2 * i, w);
		end
		dl_active = 1'b0;
		// Last write still in flight until the loader is ready again
		while (!dl_ready) @(negedge clk_sys);
	endtask

	task automatic read_byte(input int addr, input logic [7:0] expected);
		rd_valid = 1'b1;
		rd_addr  = addr[CART_ADDR_W-1:0];
		while (!rd_ready) @(negedge clk_sys);
		@(negedge clk_sys);
		rd_valid = 1'b0;
		while (!rd_resp) @(negedge clk_sys);
		check_value("rd_data", 32'(expected), 32'(rd_data));
	endtask

	task automatic read_range(input int first, input int count, input int offset);
		for (int a = first; a < first + count; a++) begin
			read_byte(a, image[a + offset]);
		end
	endtask

	task automatic random_reads(input int first, input int span, input int count);
		int addr;
		for (int n = 0; n < count; n++) begin
			repeat (int'(rand_bits(3))) @(negedge clk_sys);
			addr = first + int'(rand_bits(9)) % span;
			read_byte(addr, image[addr]);
		end
	endtask

	// Eight words, low half of each 32-bit field first
	task automatic load_cheat();
		word_t words [8];
		dl_active = 1'b0;
		@(negedge clk_sys);
		dl_index  = CODE_INDEX;
		swap      = 1'b0;
		dl_active = 1'b1;
		for (int i = 0; i < 8; i++) begin
			words[i] = rand_bits(16);
			send_word(2 * i, words[i]);
		end
		dl_active = 1'b0;
		while (!code_valid) @(negedge clk_sys);
		check_value("code flags", {words[1], words[0]}, code[127:96]);
		check_value("code address", {words[3], words[2]}, code[95:64]);
		check_value("code compare", {words[5], words[4]}, code[63:32]);
		check_value("code replace", {words[7], words[6]}, code[31:0]);
	endtask

	always @(negedge clk_sys) begin
		if (code_valid) begin
			code_pulses++;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Run timed out after %0d cycles before all tests finished", WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int chk_fails;
		dl_active = 1'b0;
		dl_index  = '0;
		dl_valid  = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		swap      = 1'b0;
		rd_valid  = 1'b0;
		rd_addr   = '0;
		@(negedge reset);
		@(negedge clk_sys);

		// Plain image
		fill_random(0, 128);
		load_image(8'd0, 1'b0, 64);
		check_value("sgx", 32'd0, 32'(sgx));
		read_range(0, 128, 0);

		// Byte swap, SuperGrafx index
		fill_random(0, 128);
		load_image(8'd1, 1'b1, 64);
		check_value("sgx", 32'd1, 32'(sgx));
		read_range(0, 128, 0);

		// 640 bytes sets size bit 9, so reads skip the copier header
		fill_random(0, 640);
		load_image(8'd0, 1'b0, 320);
		read_range(0, 128, 512);

		// Signature in block B
		fill_random(0, 'h2200);
		place_word('h2126, 16'h4F50);
		place_word('h2128, 16'h5550);
		place_word('h212A, 16'h4F4C);
		place_word('h212C, 16'h5355);
		load_image(8'd0, 1'b0, 'h1100);
		check_value("populous", 32'd1, 32'(populous));
		place_word('h212C, 16'h5354);
		load_image(8'd0, 1'b0, 'h1100);
		check_value("populous", 32'd0, 32'(populous));

		load_cheat();

		// Reads of bytes 128..479 race a reload of bytes 0..127
		fill_random(0, 480);
		load_image(8'd0, 1'b0, 240);
		fill_random(0, 128);
		fork
			load_image(8'd0, 1'b0, 64);
			random_reads(128, 352, 40);
		join
		read_range(0, 128, 0);

		check_value("code_valid pulses", 32'd1, 32'(code_pulses));
		chk_fails = int'(cart_top_inst.cart_chk_inst.dl_hold_fails +
			cart_top_inst.cart_chk_inst.rd_ready_fails +
			cart_top_inst.cart_chk_inst.rq_grant_fails +
			cart_top_inst.cart_chk_inst.code_pulse_fails);
		$display("Errors: %0d value checks, %0d handshake assertions", errors, chk_fails);
		if (errors == 0 && chk_fails == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- vlog.f
hdl/mem_pkg.sv
hdl/cart_pkg.sv
hdl/rom_store.sv
hdl/mem_arbiter.sv
hdl/cart_loader.sv
hdl/cheat_loader.sv
hdl/rom_reader.sv
hdl/cart_top.sv
dv/tb_clock.sv
dv/cart_chk.sv
dv/cart_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cart_tb -f vlog.f -Mdir obj_dir -o cart_sim

output=$(./obj_dir/cart_sim +verilator+error+limit+1000) || true
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1
